//--- bench/isaModel.svh
// Instruction-level reference model for the processor testbench
// Executes a program one instruction at a time and records the
// ordered register writes and whether it ends on an undefined opcode
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t    progMem   [IMEM_DEPTH];  // Program under test
word_t    modelRegs [8];
word_t    modelMem  [DMEM_DEPTH];  // Kept across tests, like the DUT data memory
regAddr_t expReg    [$];           // Expected write order
word_t    expData   [$];
logic     expErr;

function automatic word_t sext6(word_t instr);
    return {{10{instr[5]}}, instr[5:0]};
endfunction

function automatic word_t sext9(word_t instr);
    return {{7{instr[8]}}, instr[8:0]};
endfunction

function automatic void recordWrite(regAddr_t r, word_t v);
    modelRegs[r] = v;
    expReg.push_back(r);
    expData.push_back(v);
endfunction

task automatic runModel();
    word_t    pc;
    word_t    instr;
    word_t    srcA;
    word_t    srcB;
    word_t    addr;
    regAddr_t rd;
    logic     done;
    expReg.delete();
    expData.delete();
    expErr = 1'b0;
    done   = 1'b0;
    pc     = '0;
    for (int i = 0; i < 8; i++) begin
        modelRegs[i] = '0;  // Register file clears on reset
    end
    for (int step = 0; step < IMEM_DEPTH && !done; step++) begin
        instr = progMem[pc[7:0]];
        rd    = instr[11:9];
        srcA  = modelRegs[instr[8:6]];
        srcB  = modelRegs[instr[5:3]];
        addr  = srcA + sext6(instr);
        pc    = pc + 16'd1;
        case (instr[15:12])
            OP_ADD:  recordWrite(rd, srcA + srcB);
            OP_SUB:  recordWrite(rd, srcA - srcB);
            OP_AND:  recordWrite(rd, srcA & srcB);
            OP_XOR:  recordWrite(rd, srcA ^ srcB);
            OP_ADDI: recordWrite(rd, addr);
            OP_LBI:  recordWrite(rd, sext9(instr));
            OP_LD:   recordWrite(rd, modelMem[addr[7:0]]);
            OP_ST:   modelMem[addr[7:0]] = modelRegs[rd];
            OP_BEQZ: begin
                if (modelRegs[rd] == '0) begin
                    pc = pc + sext9(instr);  // Already points past the branch
                end
            end
            OP_HALT: done = 1'b1;
            default: begin
                expErr = 1'b1;
                done   = 1'b1;
            end
        endcase
    end
endtask

`endif

//--- bench/procTb.sv
`timescale 1ns/100ps
// Testbench for the five-stage processor
// Builds random programs, loads and runs them on the DUT and compares
// every retired register write with the instruction-level model
module procTb import isaPkg::*; ();

    logic      clk;
    logic      rst;
    logic      start;
    logic      imemWr;
    imemAddr_t imemAddr;
    word_t     imemData;
    logic      wbValid;
    regAddr_t  wbReg;
    word_t     wbData;
    logic      halted;
    logic      err;

    integer    seed;
    int        progLen;
    int        cycles;
    int        cycleLimit;  // Grows with each test's program length
    string     testName;

    `include "isaModel.svh"

    proc dut (
        .clk(clk), .rst(rst), .start(start),
        .imemWr(imemWr), .imemAddr(imemAddr), .imemData(imemData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .halted(halted), .err(err)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            stopOnError($sformatf("Timeout in %s after %0d cycles", testName, cycles));
        end
    end

    // Each retired write must be the next one the model expects
    always @(negedge clk) begin
        if (wbValid) begin
            if (expReg.size() == 0) begin
                stopOnError($sformatf("Unexpected register write in %s", testName));
            end else begin
                checkReg("wbReg", expReg.pop_front(), wbReg);
                checkData("wbData", expData.pop_front(), wbData);
            end
        end
    end

    task automatic stopOnError(string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkReg(string what, regAddr_t expVal, regAddr_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s %s expected %0d actual %0d",
                                  testName, what, expVal, actVal));
        end
    endtask

    task automatic checkData(string what, word_t expVal, word_t actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s %s expected 16'h%h actual 16'h%h",
                                  testName, what, expVal, actVal));
        end
    endtask

    task automatic checkFlag(string what, logic expVal, logic actVal);
        if (actVal !== expVal) begin
            stopOnError($sformatf("FAIL %s %s expected %b actual %b",
                                  testName, what, expVal, actVal));
        end
    endtask

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    function automatic word_t encodeR(opcode_t op, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {op, rd, rs, rt, 3'b000};
    endfunction

    function automatic word_t encodeI(opcode_t op, regAddr_t rd, regAddr_t rs, logic [5:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t encodeW(opcode_t op, regAddr_t rd, logic [8:0] imm);
        return {op, rd, imm};
    endfunction

    // Seven LBIs fill r0..r6, an optional store sweep fills data words 0..15,
    // then a random body and a final HALT or undefined opcode
    task automatic genProgram(int bodyLen, bit useMem, bit useBranch, bit endIllegal);
        logic [31:0] rnd;
        regAddr_t    rd;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    lastRd;
        int          pc;
        int          last;
        int          off;
        int          kind;
        pc     = 0;
        lastRd = '0;
        last   = 7 + (useMem ? 16 : 0) + bodyLen;
        for (int r = 0; r < 7; r++) begin
            rnd = nextRand();
            progMem[pc] = encodeW(OP_LBI, regAddr_t'(r), rnd[8:0]);
            pc++;
        end
        if (useMem) begin
            for (int a = 0; a < 16; a++) begin
                progMem[pc] = encodeI(OP_ST, regAddr_t'(a % 7), 3'd7, 6'(a));
                pc++;
            end
        end
        while (pc < last) begin
            rnd  = nextRand();
            rd   = rnd[2:0];
            rs   = rnd[3] ? lastRd : rnd[6:4];   // Frequent back-to-back use
            rt   = rnd[7] ? lastRd : rnd[10:8];
            kind = int'(rnd[31:28]);
            if ((useMem || useBranch) && rd == 3'd7) begin
                rd = 3'd6;                        // r7 stays zero as memory base
            end
            if (useBranch && kind >= 13) begin
                off = int'(rnd[17:16]);
                if (pc + 1 + off > last) begin
                    off = last - pc - 1;          // Forward only, never past the end
                end
                progMem[pc] = encodeW(OP_BEQZ, rnd[18] ? 3'd7 : lastRd, 9'(off));
            end else if (useMem && kind >= 9) begin
                progMem[pc] = encodeI(kind[0] ? OP_LD : OP_ST, kind[0] ? rd : lastRd,
                                      3'd7, {2'b00, rnd[22:19]});
            end else begin
                case (kind % 6)
                    4:       progMem[pc] = encodeI(OP_ADDI, rd, rs, rnd[16:11]);
                    5:       progMem[pc] = encodeW(OP_LBI, rd, rnd[24:16]);
                    default: progMem[pc] = encodeR(opcode_t'(kind % 6), rd, rs, rt);
                endcase
            end
            lastRd = rd;
            pc++;
        end
        rnd = nextRand();
        if (endIllegal) begin
            progMem[last] = {4'd9 + 4'(rnd[2:0] % 3'd6), rnd[11:0]};  // Opcodes 9..14
        end else begin
            progMem[last] = encodeW(OP_HALT, 3'd0, 9'd0);
        end
        progLen = last + 1;
    endtask

    task automatic applyReset();
        @(negedge clk);
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
    endtask

    // Nothing may retire and no flag may rise during the idle load
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++) begin
            imemWr   = 1'b1;
            imemAddr = imemAddr_t'(i);
            imemData = progMem[i];
            @(negedge clk);
            checkFlag("halted", 1'b0, halted);
            checkFlag("err", 1'b0, err);
        end
        imemWr = 1'b0;
    endtask

    task automatic runTest(string name, int bodyLen, bit useMem, bit useBranch,
                           bit endIllegal);
        testName = name;
        genProgram(bodyLen, useMem, useBranch, endIllegal);
        cycleLimit += progLen * 4 + 50;
        applyReset();
        loadProgram();
        repeat (2) @(negedge clk);               // Still idle before start
        runModel();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        if (expReg.size() != 0) begin
            stopOnError($sformatf("%s halted with %0d expected writes missing",
                                  testName, expReg.size()));
        end
        checkFlag("err", expErr, err);
        repeat (8) @(negedge clk);               // Late writes land in the retire checker
        checkFlag("halted", 1'b1, halted);
        checkFlag("err", expErr, err);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        imemWr     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        seed       = 46;
        cycles     = 0;
        cycleLimit = 0;
        testName   = "reset";
        for (int round = 0; round < 3; round++) begin
            runTest("aluChain", 40, 1'b0, 1'b0, 1'b0);
            runTest("loadStore", 40, 1'b1, 1'b0, 1'b0);  // Also fills the data window
            runTest("branchMix", 48, 1'b1, 1'b1, 1'b0);
            runTest("illegalOp", 24, 1'b0, 1'b0, 1'b1);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- common/isaPkg.sv
// Instruction set definitions for the 16-bit pipelined core
// Word and register types, opcodes, field positions and memory sizes
package isaPkg;

    typedef logic [15:0] word_t;      // Data or instruction word
    typedef logic [2:0]  regAddr_t;   // One of eight registers
    typedef logic [3:0]  opcode_t;    // Kept as a vector so undefined codes stay visible
    typedef logic [7:0]  imemAddr_t;  // Word address into either memory

    // Field positions inside an instruction
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;       // rd, also the stored or tested register
    localparam int RS_LSB  = 6;
    localparam int RT_LSB  = 3;

    // R-type, rd = rs op rt
    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_AND  = 4'd2;
    localparam opcode_t OP_XOR  = 4'd3;

    // Immediate forms
    localparam opcode_t OP_ADDI = 4'd4;  // rd = rs + imm6
    localparam opcode_t OP_LBI  = 4'd5;  // rd = imm9

    // Memory access at rs + imm6
    localparam opcode_t OP_LD   = 4'd6;
    localparam opcode_t OP_ST   = 4'd7;

    // Control
    localparam opcode_t OP_BEQZ = 4'd8;  // Target is pc + 1 + imm9
    localparam opcode_t OP_HALT = 4'd15;

    localparam int IMEM_DEPTH = 256;     // Words
    localparam int DMEM_DEPTH = 256;     // Words

endpackage

//--- common/pipePkg.sv
// Pipeline control definitions
// ALU function codes, forwarding selects and the fetch run states
package pipePkg;

    typedef logic [1:0] aluOp_t;
    typedef logic [1:0] fwdSel_t;

    // Same order as the R-type opcodes
    localparam aluOp_t ALU_ADD = 2'd0;
    localparam aluOp_t ALU_SUB = 2'd1;
    localparam aluOp_t ALU_AND = 2'd2;
    localparam aluOp_t ALU_XOR = 2'd3;

    localparam fwdSel_t FWD_RF  = 2'd0;  // Value read in decode
    localparam fwdSel_t FWD_MEM = 2'd1;  // EX/MEM result
    localparam fwdSel_t FWD_WB  = 2'd2;  // MEM/WB result

    typedef enum logic [1:0] {
        FS_IDLE,                         // Instruction memory may be loaded
        FS_RUN,
        FS_STOPPED                       // Halted until reset
    } fetchState_t;

endpackage

//--- decode/decode.sv
`timescale 1ns/100ps
// Decode stage
// Splits fields, extends immediates, flags undefined opcodes
// and registers ID/EX, with bubbles on stall or flush
module decode import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  word_t    ifInstr,
    input  word_t    ifPc,
    input  logic     ifValid,
    input  logic     stall,
    input  logic     flush,
    input  word_t    rfDataA, rfDataB,
    output regAddr_t rfAddrA, rfAddrB,
    output logic     exValid,
    output aluOp_t   exAluOp,
    output logic     exUseImm,
    output word_t    exImm, exPc,
    output word_t    exA, exB,
    output regAddr_t exRsA, exRsB, exRd,
    output logic     exRegWrite, exLoad, exStore,
    output logic     exBranch, exHalt, exIllegal
);

    opcode_t  opcode;
    regAddr_t rd;
    aluOp_t   aluOp;
    logic     regWrite, useImm, wideImm;
    logic     isLoad, isStore, isBranch, isHalt, illegal;
    word_t    imm;

    assign opcode  = ifInstr[OPC_LSB +: 4];
    assign rd      = ifInstr[RD_LSB +: 3];
    assign rfAddrA = ifInstr[RS_LSB +: 3];
    assign rfAddrB = (isStore || isBranch) ? rd : ifInstr[RT_LSB +: 3];  // ST data, BEQZ test

    assign imm = wideImm ? {{7{ifInstr[8]}}, ifInstr[8:0]}
                         : {{10{ifInstr[5]}}, ifInstr[5:0]};

    always_comb begin
        aluOp    = ALU_ADD;
        regWrite = 1'b0;
        useImm   = 1'b0;
        wideImm  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isHalt   = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                aluOp    = opcode[1:0];      // ALU codes mirror R-type opcodes
                regWrite = 1'b1;
            end
            OP_ADDI: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
            end
            OP_LBI: begin
                aluOp    = ALU_AND;          // Immediate passes through AND with ones
                regWrite = 1'b1;
                useImm   = 1'b1;
                wideImm  = 1'b1;
            end
            OP_LD: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                isLoad   = 1'b1;
            end
            OP_ST: begin
                useImm   = 1'b1;
                isStore  = 1'b1;
            end
            OP_BEQZ: begin
                wideImm  = 1'b1;
                isBranch = 1'b1;
            end
            OP_HALT: isHalt = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

    // ID/EX control
    always_ff @(posedge clk) begin
        if (rst || stall || flush || !ifValid) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exLoad     <= 1'b0;
            exStore    <= 1'b0;
            exBranch   <= 1'b0;
            exHalt     <= 1'b0;
            exIllegal  <= 1'b0;
        end else begin
            exValid    <= 1'b1;
            exRegWrite <= regWrite;
            exLoad     <= isLoad;
            exStore    <= isStore;
            exBranch   <= isBranch;
            exHalt     <= isHalt;
            exIllegal  <= illegal;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        exAluOp  <= aluOp;
        exUseImm <= useImm;
        exImm    <= imm;
        exPc     <= ifPc;
        exA      <= rfDataA;
        exB      <= rfDataB;
        exRsA    <= rfAddrA;
        exRsB    <= rfAddrB;
        exRd     <= rd;
    end

endmodule

//--- decode/regFile.sv
`timescale 1ns/100ps
// Register file
// Eight 16-bit registers, two combinational reads, one write port;
// a write in the same cycle is returned on a matching read
module regFile import isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t addrA,
    input  regAddr_t addrB,
    input  logic     wrEn,
    input  regAddr_t wrAddr,
    input  word_t    wrData,
    output word_t    dataA,
    output word_t    dataB
);

    word_t regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through so writeback needs no extra forwarding path
    assign dataA = (wrEn && wrAddr == addrA) ? wrData : regs[addrA];
    assign dataB = (wrEn && wrAddr == addrB) ? wrData : regs[addrB];

endmodule

//--- logic/execute.sv
`timescale 1ns/100ps
// Execute stage
// Operand forwarding, ALU, BEQZ resolution and the EX/MEM register
module execute import isaPkg::*, pipePkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     exValid,
    input  aluOp_t   exAluOp,
    input  logic     exUseImm,
    input  word_t    exImm, exPc,
    input  word_t    exA, exB,
    input  regAddr_t exRd,
    input  logic     exRegWrite, exLoad, exStore,
    input  logic     exBranch, exHalt, exIllegal,
    input  fwdSel_t  fwdA, fwdB,
    input  word_t    wbResult,
    output logic     branchTaken,
    output word_t    branchTarget,
    output logic     memValid,
    output word_t    memResult,
    output word_t    memStoreData,
    output regAddr_t memRd,
    output logic     memRegWrite, memLoad, memStore,
    output logic     memHalt, memIllegal
);

    word_t srcA, srcB, opA, opB, result;

    function automatic word_t pickSrc(fwdSel_t sel, word_t rf, word_t memVal, word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return rf;
        endcase
    endfunction

    assign srcA = pickSrc(fwdA, exA, memResult, wbResult);
    assign srcB = pickSrc(fwdB, exB, memResult, wbResult);  // Also ST data and BEQZ test
    assign opA  = (exUseImm && exAluOp == ALU_AND) ? '1 : srcA;  // LBI
    assign opB  = exUseImm ? exImm : srcB;

    always_comb begin
        case (exAluOp)
            ALU_SUB: result = opA - opB;
            ALU_AND: result = opA & opB;
            ALU_XOR: result = opA ^ opB;
            default: result = opA + opB;                   // ADD, ADDI, LD/ST address
        endcase
    end

    assign branchTaken  = exValid && exBranch && srcB == '0;
    assign branchTarget = exPc + 16'd1 + exImm;

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (rst) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memLoad     <= 1'b0;
            memStore    <= 1'b0;
            memHalt     <= 1'b0;
            memIllegal  <= 1'b0;
        end else begin
            memValid    <= exValid;
            memRegWrite <= exRegWrite;
            memLoad     <= exLoad;
            memStore    <= exStore;
            memHalt     <= exHalt;
            memIllegal  <= exIllegal;
        end
    end

    always_ff @(posedge clk) begin
        memResult    <= result;
        memStoreData <= srcB;
        memRd        <= exRd;
    end

endmodule

//--- logic/fetch.sv
`timescale 1ns/100ps
// Fetch stage
// Instruction memory with an idle-time write port, the PC,
// the run state machine and the IF/ID register
module fetch import isaPkg::*, pipePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      imemWr,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    input  logic      stall,
    input  logic      branchTaken,
    input  word_t     branchTarget,
    input  logic      halted,
    output word_t     ifInstr,
    output word_t     ifPc,
    output logic      ifValid
);

    word_t       imem [IMEM_DEPTH];
    word_t       pc;
    fetchState_t state;

    always_ff @(posedge clk) begin
        if (imemWr && state == FS_IDLE) begin  // Program load only while idle
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FS_IDLE;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (start) begin
                        state <= FS_RUN;
                    end
                end
                FS_RUN: begin
                    if (halted) begin
                        state <= FS_STOPPED;
                    end
                end
                default: begin
                    state <= FS_STOPPED;       // Stays here until reset
                end
            endcase
        end
    end

    // PC and IF/ID valid
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            ifValid <= 1'b0;
        end else if (state != FS_RUN || halted) begin
            ifValid <= 1'b0;
        end else if (branchTaken) begin
            pc      <= branchTarget;         // Redirect and squash wrong path
            ifValid <= 1'b0;
        end else if (!stall) begin
            pc      <= pc + 16'd1;
            ifValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin                    // Load-use hold
            ifInstr <= imem[pc[7:0]];
            ifPc    <= pc;
        end
    end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/100ps
// Hazard unit
// Forwarding selects for the execute operands, load-use stall
// and flush on a taken branch
module hazardUnit import isaPkg::*, pipePkg::*; (
    input  regAddr_t idRsA, idRsB,
    input  regAddr_t exRsA, exRsB,
    input  logic     exLoad,
    input  regAddr_t exRd,
    input  logic     exRegWrite,
    input  regAddr_t memRd,
    input  logic     memRegWrite,
    input  regAddr_t wbRd,
    input  logic     wbRegWrite,
    input  logic     branchTaken,
    output fwdSel_t  fwdA, fwdB,
    output logic     stall,
    output logic     flush
);

    // Youngest producer wins
    function automatic fwdSel_t pickFwd(logic memHit, logic wbHit);
        if (memHit) begin
            return FWD_MEM;
        end else if (wbHit) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwdA = pickFwd(memRegWrite && memRd == exRsA, wbRegWrite && wbRd == exRsA);
    assign fwdB = pickFwd(memRegWrite && memRd == exRsB, wbRegWrite && wbRd == exRsB);

    // Load data is ready one stage too late for the next instruction
    assign stall = exLoad && exRegWrite && (exRd == idRsA || exRd == idRsB);
    assign flush = branchTaken;

endmodule

//--- logic/memStage.sv
`timescale 1ns/100ps
// Memory stage
// Data memory, load or ALU result select, the MEM/WB register
// and the sticky halted and err flags
module memStage import isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     memValid,
    input  word_t    memResult,
    input  word_t    memStoreData,
    input  regAddr_t memRd,
    input  logic     memRegWrite, memLoad, memStore,
    input  logic     memHalt, memIllegal,
    output logic     wbValid,
    output regAddr_t wbReg,
    output word_t    wbData,
    output logic     halted,
    output logic     err
);

    word_t     dmem [DMEM_DEPTH];
    imemAddr_t addr;

    assign addr = memResult[7:0];

    always_ff @(posedge clk) begin
        if (memValid && memStore && !halted) begin  // Nothing past a halt lands in memory
            dmem[addr] <= memStoreData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else begin
            wbValid <= memValid && memRegWrite && !halted;
            halted  <= halted || (memValid && (memHalt || memIllegal));
            err     <= err || (memValid && memIllegal && !halted);
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= memRd;
        wbData <= memLoad ? dmem[addr] : memResult;
    end

endmodule

//--- logic/proc.sv
`timescale 1ns/100ps
// Five-stage 16-bit processor top level
// Wires fetch, decode, register file, hazard unit, execute and memory
module proc import isaPkg::*, pipePkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      imemWr,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    output logic      wbValid,
    output regAddr_t  wbReg,
    output word_t     wbData,
    output logic      halted,
    output logic      err
);

    // IF/ID
    word_t    ifInstr, ifPc;
    logic     ifValid;

    // Register file reads
    regAddr_t rfAddrA, rfAddrB;
    word_t    rfDataA, rfDataB;

    // ID/EX
    logic     exValid, exUseImm;
    aluOp_t   exAluOp;
    word_t    exImm, exPc, exA, exB;
    regAddr_t exRsA, exRsB, exRd;
    logic     exRegWrite, exLoad, exStore, exBranch, exHalt, exIllegal;

    // Hazard control
    fwdSel_t  fwdA, fwdB;
    logic     stall, flush;
    logic     branchTaken;
    word_t    branchTarget;

    // EX/MEM
    logic     memValid;
    word_t    memResult, memStoreData;
    regAddr_t memRd;
    logic     memRegWrite, memLoad, memStore, memHalt, memIllegal;

    fetch fetchStage (
        .clk(clk), .rst(rst), .start(start),
        .imemWr(imemWr), .imemAddr(imemAddr), .imemData(imemData),
        .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
        .halted(halted),
        .ifInstr(ifInstr), .ifPc(ifPc), .ifValid(ifValid)
    );

    decode decodeStage (
        .clk(clk), .rst(rst),
        .ifInstr(ifInstr), .ifPc(ifPc), .ifValid(ifValid),
        .stall(stall), .flush(flush),
        .rfDataA(rfDataA), .rfDataB(rfDataB),
        .rfAddrA(rfAddrA), .rfAddrB(rfAddrB),
        .exValid(exValid), .exAluOp(exAluOp), .exUseImm(exUseImm),
        .exImm(exImm), .exPc(exPc), .exA(exA), .exB(exB),
        .exRsA(exRsA), .exRsB(exRsB), .exRd(exRd),
        .exRegWrite(exRegWrite), .exLoad(exLoad), .exStore(exStore),
        .exBranch(exBranch), .exHalt(exHalt), .exIllegal(exIllegal)
    );

    regFile regs (
        .clk(clk), .rst(rst),
        .addrA(rfAddrA), .addrB(rfAddrB),
        .wrEn(wbValid), .wrAddr(wbReg), .wrData(wbData),  // Retire port
        .dataA(rfDataA), .dataB(rfDataB)
    );

    hazardUnit hazards (
        .idRsA(rfAddrA), .idRsB(rfAddrB),
        .exRsA(exRsA), .exRsB(exRsB),
        .exLoad(exLoad), .exRd(exRd), .exRegWrite(exRegWrite),
        .memRd(memRd), .memRegWrite(memRegWrite),
        .wbRd(wbReg), .wbRegWrite(wbValid),
        .branchTaken(branchTaken),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    execute executeStage (
        .clk(clk), .rst(rst),
        .exValid(exValid), .exAluOp(exAluOp), .exUseImm(exUseImm),
        .exImm(exImm), .exPc(exPc), .exA(exA), .exB(exB), .exRd(exRd),
        .exRegWrite(exRegWrite), .exLoad(exLoad), .exStore(exStore),
        .exBranch(exBranch), .exHalt(exHalt), .exIllegal(exIllegal),
        .fwdA(fwdA), .fwdB(fwdB), .wbResult(wbData),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .memValid(memValid), .memResult(memResult), .memStoreData(memStoreData),
        .memRd(memRd), .memRegWrite(memRegWrite), .memLoad(memLoad),
        .memStore(memStore), .memHalt(memHalt), .memIllegal(memIllegal)
    );

    memStage memoryStage (
        .clk(clk), .rst(rst),
        .memValid(memValid), .memResult(memResult), .memStoreData(memStoreData),
        .memRd(memRd), .memRegWrite(memRegWrite), .memLoad(memLoad),
        .memStore(memStore), .memHalt(memHalt), .memIllegal(memIllegal),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .halted(halted), .err(err)
    );

endmodule

//--- proc.f
+incdir+bench
common/isaPkg.sv
common/pipePkg.sv
logic/fetch.sv
decode/regFile.sv
decode/decode.sv
logic/hazardUnit.sv
logic/execute.sv
logic/memStage.sv
logic/proc.sv
bench/procTb.sv
